//--- sim.f
+incdir+bench
src/bridge_pkg.sv
src/ahb_decode.sv
src/apb_sequencer.sv
src/apb_response.sv
src/ahb_apb_bridge.sv
bench/bridge_tb.sv

//--- Makefile
# Verilator build and run for the AHB to APB bridge testbench

SIM := obj_dir/Vbridge_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM): sim.f $(wildcard src/*.sv bench/*.sv bench/*.svh)
	verilator --binary --timing --assert --top-module bridge_tb -f sim.f -o Vbridge_tb

# A $fatal in the testbench gives a failing exit status
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

//--- bench/bridge_checks.svh
// Compare tasks and bounded wait loops for the AHB to APB bridge testbench
`ifndef BRIDGE_CHECKS_SVH
`define BRIDGE_CHECKS_SVH

// ------------------------------
// Failure reporting
// ------------------------------

task automatic stop_run;
  $display("SIMULATION FAILED");
  $fatal(1, "Run stopped at the first error");
endtask

task automatic report_timeout(input string what);
  $display("Timeout: no %s within 50 clock cycles", what);
  stop_run();
endtask

// ------------------------------
// Compare tasks
// ------------------------------

task automatic check_data(input data_t got, input data_t exp, input string what);
  if (got !== exp) begin
    $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    stop_run();
  end
endtask

task automatic check_sel(input sel_t got, input sel_t exp, input string what);
  if (got !== exp) begin
    $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
    stop_run();
  end
endtask

task automatic check_addr(input addr_t got, input addr_t exp, input string what);
  if (got !== exp) begin
    $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    stop_run();
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
    stop_run();
  end
endtask

// Cycle counts are taken from the acceptance edge
task automatic check_cycles(input int got, input int exp, input string what);
  if (got != exp) begin
    $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    stop_run();
  end
endtask

// ------------------------------
// Bounded waits
// ------------------------------

task automatic wait_hready(input string what);
  int n;
  n = 0;
  while (!hready && n < 50) begin
    @(negedge hclk17);
    n++;
  end
  if (!hready) begin
    report_timeout(what);
  end
endtask

`endif

//--- bench/bridge_tb.sv
// Testbench for the AHB to APB bridge with four APB slave models and directed tests
`timescale 1ns/1ns

module bridge_tb
  import bridge_pkg::*;
();

  logic        hclk17;
  logic        hreset_n17;
  logic        hsel;
  addr_t       haddr;
  htrans_t     htrans;
  logic        hwrite;
  data_t       hwdata;
  logic        hready;
  data_t       hrdata;
  sel_t        psel;
  logic        penable;
  logic        pwrite;
  addr_t       paddr;
  data_t       pwdata;
  sel_t        pready;
  prdata_bus_t prdata;

  data_t       slave_mem [NUM_SLAVES][16];
  data_t       ref_mem [NUM_SLAVES][16];
  logic [1:0]  wait_cnt [NUM_SLAVES];
  logic [1:0]  access_waits;
  logic        waits_on;
  data_t       last_rdata;
  logic [31:0] lfsr = 32'hf5d;

  ahb_apb_bridge uut (.*);

  `include "bridge_checks.svh"

  initial begin
    hclk17 = 1'b0;
    forever #2 hclk17 = ~hclk17;
  end

  // Galois LFSR, one step per bit taken
  function automatic data_t next_bits(input int n);
    data_t v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Power-up contents, every address bit takes part
  function automatic data_t fill_word(input addr_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
  endfunction

  // One 4 KB window per slave, nothing from 0x4000 up
  function automatic sel_t window_sel(input addr_t a);
    if (a >= addr_t'(NUM_SLAVES) * SLAVE_SPAN) begin
      return '0;
    end
    return sel_t'(1) << (a / SLAVE_SPAN);
  endfunction

  function automatic addr_t random_addr(input int s);
    return SLAVE_BASE[s] | (next_bits(12) & 32'h0000_0ffc);
  endfunction

  // ------------------------------
  // APB slave models
  // ------------------------------

  initial begin
    pready = '0;
    prdata = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      wait_cnt[i] = 2'd0;
      for (int w = 0; w < 16; w++) begin
        slave_mem[i][w] = fill_word(SLAVE_BASE[i] + (addr_t'(w) << 2));
      end
    end
    forever begin
      @(negedge hclk17);
      for (int i = 0; i < NUM_SLAVES; i++) begin
        pready[i] = 1'b0;
        if (psel[i] && !penable) begin
          wait_cnt[i] = access_waits;
        end else if (psel[i] && penable && wait_cnt[i] != 2'd0) begin
          wait_cnt[i] = wait_cnt[i] - 2'd1;
        end else if (psel[i] && penable) begin
          pready[i] = 1'b1;
          if (pwrite) begin
            slave_mem[i][paddr[5:2]] = pwdata;
          end else begin
            prdata[i] = slave_mem[i][paddr[5:2]];
          end
        end
      end
    end
  end

  // ------------------------------
  // AHB master with APB phase monitor
  // ------------------------------

  task automatic run_transfer(input addr_t addr, input logic write, input data_t wdata,
                              input data_t exp_rdata);
    sel_t  exp_sel;
    int    psel_at;
    int    pen_at;
    int    done_at;
    exp_sel      = window_sel(addr);
    psel_at      = -1;
    pen_at       = -1;
    done_at      = -1;
    access_waits = waits_on ? 2'(next_bits(2)) : 2'd0;
    wait_hready("hready before starting a transfer");
    hsel       = 1'b1;
    htrans     = HTRANS_NONSEQ;
    haddr      = addr;
    hwrite     = write;
    @(negedge hclk17);
    // Data phase, hwdata held until hready returns
    hsel   = 1'b0;
    htrans = HTRANS_IDLE;
    hwdata = wdata;
    for (int j = 0; j < 50 && done_at < 0; j++) begin
      if (hready) begin
        done_at = j;
      end else begin
        psel_at = (psel != '0 && psel_at < 0) ? j : psel_at;
        pen_at  = (penable && pen_at < 0) ? j : pen_at;
        if (psel != '0 || exp_sel == '0) begin
          check_sel(psel, exp_sel, "psel during the APB transfer");
        end
        if (psel != '0) begin
          check_addr(paddr, addr, "paddr during the APB transfer");
          check_flag(pwrite, write, "pwrite during the APB transfer");
          if (write) begin
            check_data(pwdata, wdata, "pwdata during the APB write");
          end
        end
        @(negedge hclk17);
      end
    end
    if (done_at < 0) begin
      report_timeout("hready after an accepted transfer");
    end
    if (exp_sel != '0) begin
      check_cycles(psel_at, 1, "cycles from acceptance to psel");
      check_cycles(pen_at, 2, "cycles from acceptance to penable");
    end
    check_cycles(done_at, 3 + ((exp_sel != '0) ? int'(access_waits) : 0),
                 "cycles from acceptance to completion");
    if (write) begin
      check_data(hrdata, last_rdata, "hrdata after a write");
    end else begin
      check_data(hrdata, exp_rdata, "hrdata after a read");
      last_rdata = exp_rdata;
    end
  endtask

  task automatic write_word(input addr_t addr, input data_t data);
    run_transfer(addr, 1'b1, data, '0);
    if (window_sel(addr) != '0) begin
      ref_mem[addr[13:12]][addr[5:2]] = data;
    end
  endtask

  task automatic read_word(input addr_t addr);
    data_t exp;
    exp = (window_sel(addr) != '0) ? ref_mem[addr[13:12]][addr[5:2]] : '0;
    run_transfer(addr, 1'b0, '0, exp);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  task automatic test_window_rw;
    addr_t a;
    waits_on = 1'b0;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      a = random_addr(s);
      write_word(a, next_bits(32));
      read_word(a);
    end
  endtask

  task automatic test_apb_phases;
    waits_on = 1'b0;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      read_word(random_addr(s));
      write_word(random_addr(s), next_bits(32));
    end
  endtask

  task automatic test_wait_states;
    addr_t a;
    waits_on = 1'b1;
    for (int k = 0; k < 12; k++) begin
      a = random_addr(int'(next_bits(2)));
      read_word(a);
      write_word(a, next_bits(32));
      read_word(a);
    end
    waits_on = 1'b0;
  endtask

  // Mapped read first so a zero from the miss is visible
  task automatic test_unmapped;
    addr_t a;
    a = 32'h0000_4000 | (next_bits(28) & 32'h0fff_fffc);
    read_word(random_addr(1));
    write_word(a, next_bits(32));
    read_word(a);
    write_word(32'hffff_fffc, next_bits(32));
    read_word(32'hffff_fffc);
  endtask

  task automatic test_idle_cycles;
    wait_hready("hready before the idle cycles");
    for (int k = 0; k < 7; k++) begin
      hsel   = (k % 3 != 0);
      htrans = (k % 3 == 0) ? HTRANS_NONSEQ : ((k % 3 == 1) ? HTRANS_IDLE : HTRANS_BUSY);
      haddr  = SLAVE_BASE[k % NUM_SLAVES];
      hwrite = k[0];
      @(negedge hclk17);
      check_sel(psel, '0, "psel during an idle cycle");
      check_flag(hready, 1'b1, "hready during an idle cycle");
    end
    hsel   = 1'b0;
    htrans = HTRANS_IDLE;
  endtask

  initial begin
    hreset_n17   = 1'b0;
    hsel         = 1'b0;
    haddr        = '0;
    htrans       = HTRANS_IDLE;
    hwrite       = 1'b0;
    hwdata       = '0;
    waits_on     = 1'b0;
    access_waits = 2'd0;
    last_rdata   = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      for (int w = 0; w < 16; w++) begin
        ref_mem[i][w] = fill_word(SLAVE_BASE[i] + (addr_t'(w) << 2));
      end
    end
    repeat (5) @(posedge hclk17);
    @(negedge hclk17);
    hreset_n17 = 1'b1;
    check_flag(hready, 1'b1, "hready after reset");
    check_data(hrdata, '0, "hrdata after reset");
    check_sel(psel, '0, "psel after reset");
    test_window_rw();
    test_apb_phases();
    test_wait_states();
    test_unmapped();
    test_idle_cycles();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- src/ahb_apb_bridge.sv
// AHB to APB bridge top that ties the decode, sequencing and response stages to the buses
`timescale 1ns/1ns

module ahb_apb_bridge
  import bridge_pkg::*;
(
  input  logic        hclk17,
  input  logic        hreset_n17,
  // AHB slave side
  input  logic        hsel,
  input  addr_t       haddr,
  input  htrans_t     htrans,
  input  logic        hwrite,
  input  data_t       hwdata,
  output logic        hready,
  output data_t       hrdata,
  // APB master side
  output sel_t        psel,
  output logic        penable,
  output logic        pwrite,
  output addr_t       paddr,
  output data_t       pwdata,
  input  sel_t        pready,
  input  prdata_bus_t prdata
);

  ahb_req_t req;
  apb_bus_t apb;
  logic     pending;
  logic     done;

  ahb_decode u_decode (
    .hclk17     (hclk17),
    .hreset_n17 (hreset_n17),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .done       (done),
    .hready     (hready),
    .pending    (pending),
    .req        (req)
  );

  apb_sequencer u_sequencer (
    .hclk17     (hclk17),
    .hreset_n17 (hreset_n17),
    .pending    (pending),
    .req        (req),
    .done       (done),
    .apb        (apb)
  );

  apb_response u_response (
    .hclk17     (hclk17),
    .hreset_n17 (hreset_n17),
    .apb        (apb),
    .pready     (pready),
    .prdata     (prdata),
    .done       (done),
    .hrdata     (hrdata)
  );

  // ------------------------------
  // APB port unpacking
  // ------------------------------

  assign psel    = apb.psel;
  assign penable = apb.penable;
  assign pwrite  = apb.pwrite;
  assign paddr   = apb.paddr;

  // Master holds hwdata while hready is low
  assign pwdata = hwdata;

endmodule

//--- src/apb_response.sv
// APB response mux that picks the active slave, flags completion and returns read data
`timescale 1ns/1ns

module apb_response
  import bridge_pkg::*;
(
  input  logic        hclk17,
  input  logic        hreset_n17,
  input  apb_bus_t    apb,
  input  sel_t        pready,
  input  prdata_bus_t prdata,
  output logic        done,
  output data_t       hrdata
);

  logic  no_slave;
  logic  pready_mux;
  data_t prdata_mux;

  // ------------------------------
  // Slave response select
  // ------------------------------

  // Unmapped address, nobody to wait for
  assign no_slave   = ~|apb.psel;
  assign pready_mux = no_slave || |(apb.psel & pready);

  // AND-OR mux, gives zero when no slave is selected
  always_comb begin
    prdata_mux = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      prdata_mux = prdata_mux | (prdata[i] & {$bits(data_t){apb.psel[i]}});
    end
  end

  // penable is only high in the access phase
  assign done = apb.penable && pready_mux;

  // Read data register, keeps the last read across writes
  always_ff @(posedge hclk17 or negedge hreset_n17) begin
    if (!hreset_n17) begin
      hrdata <= '0;
    end else if (done && !apb.pwrite) begin
      hrdata <= prdata_mux;
    end
  end

endmodule

//--- src/apb_sequencer.sv
// APB master state machine that runs the setup and access phases of one transfer
`timescale 1ns/1ns

module apb_sequencer
  import bridge_pkg::*;
(
  input  logic     hclk17,
  input  logic     hreset_n17,
  input  logic     pending,
  input  ahb_req_t req,
  input  logic     done,
  output apb_bus_t apb
);

  apb_state_t state;
  apb_state_t state_nxt;

  // ------------------------------
  // Next state
  // ------------------------------

  always_comb begin
    state_nxt = state;
    unique case (state)
      APB_IDLE: begin
        if (pending) begin
          state_nxt = APB_SETUP;
        end
      end
      APB_SETUP: begin
        state_nxt = APB_ACCESS;
      end
      APB_ACCESS: begin
        // Stretched here while the slave holds pready low
        if (done) begin
          state_nxt = APB_IDLE;
        end
      end
      default: begin
        state_nxt = APB_IDLE;
      end
    endcase
  end

  always_ff @(posedge hclk17 or negedge hreset_n17) begin
    if (!hreset_n17) begin
      state <= APB_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ------------------------------
  // APB outputs
  // ------------------------------

  always_ff @(posedge hclk17 or negedge hreset_n17) begin
    if (!hreset_n17) begin
      apb <= '0;
    end else begin
      unique case (state)
        APB_IDLE: begin
          // Setup phase, select and address go out with penable low
          if (pending) begin
            apb.psel    <= req.sel;
            apb.paddr   <= req.addr;
            apb.pwrite  <= req.write;
            apb.penable <= 1'b0;
          end
        end
        APB_SETUP: begin
          apb.penable <= 1'b1;
        end
        APB_ACCESS: begin
          if (done) begin
            apb.psel    <= '0;
            apb.penable <= 1'b0;
          end
        end
        default: begin
          apb.psel    <= '0;
          apb.penable <= 1'b0;
        end
      endcase
    end
  end

  // ------------------------------
  // Protocol checks
  // ------------------------------

  a_psel_onehot: assert property (
    @(posedge hclk17) disable iff (!hreset_n17)
    $onehot0(apb.psel)
  );

  // Slave sees the held request for the whole access phase
  a_access_stable: assert property (
    @(posedge hclk17) disable iff (!hreset_n17)
    (state == APB_ACCESS) |->
      ((apb.paddr == req.addr) && (apb.psel == req.sel) && (apb.pwrite == req.write))
  );

endmodule

//--- src/ahb_decode.sv
// AHB slave front end that accepts transfers, holds the data phase and decodes the slave select
`timescale 1ns/1ns

module ahb_decode
  import bridge_pkg::*;
(
  input  logic     hclk17,
  input  logic     hreset_n17,
  input  logic     hsel,
  input  addr_t    haddr,
  input  htrans_t  htrans,
  input  logic     hwrite,
  input  logic     done,
  output logic     hready,
  output logic     pending,
  output ahb_req_t req
);

  logic active_trans;
  logic accept;
  sel_t sel_dec;

  // ------------------------------
  // Transfer acceptance
  // ------------------------------

  // Only NONSEQ and SEQ start work, IDLE and BUSY are ignored
  assign active_trans = (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);
  assign accept       = hready && hsel && active_trans;

  // Bus is stalled for the whole APB transfer
  assign hready = ~pending;

  // ------------------------------
  // Window decode
  // ------------------------------

  // No bit set when haddr misses every window
  always_comb begin
    sel_dec = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if ((haddr >= SLAVE_BASE[i]) && (haddr < (SLAVE_BASE[i] + SLAVE_SPAN))) begin
        sel_dec[i] = 1'b1;
      end
    end
  end

  // Data phase flag, held until the APB side reports completion
  always_ff @(posedge hclk17 or negedge hreset_n17) begin
    if (!hreset_n17) begin
      pending <= 1'b0;
    end else if (accept) begin
      pending <= 1'b1;
    end else if (done) begin
      pending <= 1'b0;
    end
  end

  // Address phase capture
  always_ff @(posedge hclk17) begin
    if (accept) begin
      req.addr  <= haddr;
      req.write <= hwrite;
      req.sel   <= sel_dec;
    end
  end

  // Completion only ever arrives for a transfer in flight
  a_done_pending: assert property (
    @(posedge hclk17) disable iff (!hreset_n17)
    done |-> pending
  );

endmodule

//--- src/bridge_pkg.sv
// AHB to APB bridge shared widths, bus types, transfer codes and slave address map
package bridge_pkg;

  // ------------------------------
  // Slave address map
  // ------------------------------

  localparam int NUM_SLAVES = 4;

  // Plain vector types
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [NUM_SLAVES-1:0] sel_t;

  // Read data of all slaves, slave 0 in the low word
  typedef data_t [NUM_SLAVES-1:0] prdata_bus_t;

  // Each slave owns one 4 KB window
  localparam addr_t SLAVE_SPAN = 32'h1000;

  // Window start of each slave, 0x4000 and above is unmapped
  localparam addr_t SLAVE_BASE [NUM_SLAVES] = '{
    32'(0 * SLAVE_SPAN),
    32'(1 * SLAVE_SPAN),
    32'(2 * SLAVE_SPAN),
    32'(3 * SLAVE_SPAN)
  };

  // ------------------------------
  // Protocol encodings
  // ------------------------------

  // AHB htrans codes
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_t;

  // APB sequencing states
  typedef enum logic [1:0] {
    APB_IDLE   = 2'b00,
    APB_SETUP  = 2'b01,
    APB_ACCESS = 2'b10
  } apb_state_t;

  // Captured AHB transfer
  typedef struct packed {
    addr_t addr;
    logic  write;
    sel_t  sel;
  } ahb_req_t;

  // Outgoing APB control
  typedef struct packed {
    sel_t  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
  } apb_bus_t;

endpackage
